/* build.f */
common/hart_pkg.sv
hart_select/hart_sched_regs.sv
hart_select/hart_selector.sv
hw/hart_pc_file.sv
hw/mt_fetch_top.sv
test/mt_fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator and runs it.
# Exit status is zero only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR="obj_dir"
SIM_BIN="mt_fetch_sim"
LOG_FILE="sim.log"

if ! command -v verilator > /dev/null 2>&1; then
    echo "run_sim: verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mt_fetch_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN" -f build.f
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulator exited with status $sim_status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG_FILE"; then
    echo "run_sim: test run passed"
    exit 0
fi
echo "run_sim: test run failed"
exit 1

/* test/mt_fetch_tb.sv */
/* Testbench for the multithreaded fetch front end. A cycle model checks every output,
   and directed tests walk reset, rotation, misses, masks, redirects and terminations. */
`timescale 1ns/1ps
`default_nettype none

module mt_fetch_tb;

    localparam int CLK_HALF_NS  = 10;
    // Per-test cycle budgets in run order, from reset to termination.
    localparam int BUDGET_CYCLES = 20 + 80 + 160 + 70 + 20 + 70;
    localparam int WATCHDOG_NS   = (BUDGET_CYCLES + 100) * 2 * CLK_HALF_NS;

    logic                   CLK;
    logic                   nRST;
    hart_pkg::cfg_write_t   cfg;
    hart_pkg::pipe_events_t events;
    hart_pkg::redirect_t    redirect;
    hart_pkg::fetch_req_t   fetch;
    logic                   halt_proc;

    int          check_errors = 0;                  // Directed check failures.
    int          model_errors = 0;                  // Model compare failures.
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          err_mark;
    logic [31:0] lfsr_state   = 32'h773d_d20b;      // Stimulus seed.
    int          fetched [hart_pkg::NUM_HARTS];     // Fetches seen per hart.
    hart_pkg::hart_id_t ring_pos;                   // Hart expected in rotation.

    // Reference model state.
    hart_pkg::hart_mask_t           m_live, m_live_next, m_enable;
    logic [hart_pkg::QUANTUM_W-1:0] m_quantum, m_count;
    hart_pkg::hart_id_t             m_hart;
    logic                           m_armed, m_fetch, m_switch;
    hart_pkg::word_t                m_pc [hart_pkg::NUM_HARTS];
    logic                           exp_valid, exp_halt, outputs_match;
    hart_pkg::word_t                exp_pc;

    mt_fetch_top dut_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .cfg       (cfg),
        .events    (events),
        .redirect  (redirect),
        .fetch     (fetch),
        .halt_proc (halt_proc)
    );

    always #(CLK_HALF_NS) CLK = ~CLK;               // 20 ns period.

    function automatic hart_pkg::word_t reset_pc(input hart_pkg::hart_id_t h);
        return hart_pkg::RESET_PC_BASE + hart_pkg::word_t'(h) * hart_pkg::HART_PC_STRIDE;
    endfunction

    // First hart after cur in the mask, cur itself if none.
    function automatic hart_pkg::hart_id_t ring_next(input hart_pkg::hart_id_t cur,
                                                     input hart_pkg::hart_mask_t mask);
        hart_pkg::hart_id_t pick;
        hart_pkg::hart_id_t idx;
        pick = cur;
        for (int step = hart_pkg::NUM_HARTS - 1; step >= 1; step--) begin
            idx = hart_pkg::hart_id_t'((int'(cur) + step) % hart_pkg::NUM_HARTS);
            if (mask[idx]) begin
                pick = idx;                         // Nearest one wins last.
            end
        end
        return pick;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    always_comb begin
        m_fetch     = m_armed && m_live[m_hart] && m_enable[m_hart] &&
                      events.pc_en && !events.flush;
        m_live_next = m_live;
        if (events.thread_terminated) begin
            m_live_next[events.term_hart] = 1'b0;   // Gone from this edge on.
        end
        m_switch = events.cache_miss || events.thread_terminated ||
                   (m_fetch && (int'(m_count) + 1 >= int'(m_quantum)));
    end

    assign exp_valid     = m_armed && m_live[m_hart] && m_enable[m_hart];
    assign exp_halt      = (m_live == '0);
    assign exp_pc        = m_pc[m_hart];
    assign outputs_match = (fetch.valid === exp_valid) && (fetch.hart === m_hart) &&
                           (fetch.pc === exp_pc) && (halt_proc === exp_halt);

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            m_live    <= '1;
            m_enable  <= '1;
            m_quantum <= hart_pkg::RESET_QUANTUM;
            m_count   <= '0;
            m_hart    <= '0;
            m_armed   <= 1'b0;
            for (int h = 0; h < hart_pkg::NUM_HARTS; h++) begin
                m_pc[h] <= reset_pc(hart_pkg::hart_id_t'(h));
            end
        end else begin
            m_armed <= 1'b1;                        // First fetch one cycle late.
            m_live  <= m_live_next;
            if (cfg.wr && cfg.addr == hart_pkg::CFG_ADDR_QUANTUM) begin
                m_quantum <= (cfg.data[hart_pkg::QUANTUM_W-1:0] == '0) ?
                             hart_pkg::QUANTUM_W'(1) : cfg.data[hart_pkg::QUANTUM_W-1:0];
            end
            if (cfg.wr && cfg.addr == hart_pkg::CFG_ADDR_ENABLE) begin
                m_enable <= cfg.data[hart_pkg::NUM_HARTS-1:0];
            end
            if (m_switch) begin
                m_count <= '0;
                m_hart  <= ring_next(m_hart, m_live_next & m_enable);
            end else if (m_fetch) begin
                m_count <= m_count + 1'b1;
            end
            if (m_fetch) begin
                m_pc[m_hart] <= m_pc[m_hart] + 32'd4;
            end
            if (redirect.valid) begin
                m_pc[redirect.hart] <= redirect.target;  // Later write wins.
            end
        end
    end

    // Model compare after reset, quiet fetch during reset.
    check_outputs: assert property (@(posedge CLK) (nRST ? outputs_match : !fetch.valid))
    else begin
        if (!$sampled(nRST)) begin
            $display("FAIL t=%0t fetch.valid expected 0 actual %0b during reset", $time,
                     $sampled(fetch.valid));
        end else begin
            if ($sampled(fetch.valid) !== $sampled(exp_valid))
                $display("FAIL t=%0t fetch.valid expected %0b actual %0b", $time,
                         $sampled(exp_valid), $sampled(fetch.valid));
            if ($sampled(fetch.hart) !== $sampled(m_hart))
                $display("FAIL t=%0t fetch.hart expected %0d actual %0d", $time,
                         $sampled(m_hart), $sampled(fetch.hart));
            if ($sampled(fetch.pc) !== $sampled(exp_pc))
                $display("FAIL t=%0t fetch.pc expected %h actual %h", $time,
                         $sampled(exp_pc), $sampled(fetch.pc));
            if ($sampled(halt_proc) !== $sampled(exp_halt))
                $display("FAIL t=%0t halt_proc expected %0b actual %0b", $time,
                         $sampled(exp_halt), $sampled(halt_proc));
        end
        model_errors++;
    end

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            check_errors++;
        end
    endtask

    // Advance one edge, drive 1 ns later, drop pulses.
    task automatic next_cycle();
        @(posedge CLK);
        #1;
        cfg.wr                   = 1'b0;
        events.cache_miss        = 1'b0;
        events.thread_terminated = 1'b0;
        redirect.valid           = 1'b0;
    endtask

    task automatic apply_reset();
        nRST     = 1'b0;
        cfg      = '0;
        events   = '0;
        redirect = '0;
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;
    endtask

    task automatic wait_for_valid(input int limit);
        int n;
        n = 0;
        while (!fetch.valid && n < limit) begin
            next_cycle();
            n++;
        end
        assert (fetch.valid)
        else begin
            $display("Error at %0t: fetch.valid did not rise within %0d cycles", $time, limit);
            check_errors++;
        end
    endtask

    // AND of n fresh bits, one LFSR step each.
    task automatic take_bits(input int n, output logic all_ones);
        all_ones = 1'b1;
        for (int i = 0; i < n; i++) begin
            all_ones   = all_ones & lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic write_cfg(input hart_pkg::cfg_addr_t addr, input logic [31:0] data);
        cfg.wr   = 1'b1;
        cfg.addr = addr;
        cfg.data = data;
    endtask

    task automatic end_thread(input hart_pkg::hart_id_t h);
        events.thread_terminated = 1'b1;
        events.term_hart         = h;
        next_cycle();
    endtask

    // Walk whole turns, checking hart order and resumed PCs.
    task automatic rotate_turns(input int turns, input int q, input logic wr_q);
        for (int t = 0; t < turns; t++) begin
            for (int j = 0; j < q; j++) begin
                check_eq("fetch.hart", 32'(ring_pos), 32'(fetch.hart));
                check_eq("fetch.pc", reset_pc(ring_pos) + 32'(4 * fetched[ring_pos]), fetch.pc);
                if (wr_q && t == 0 && j == 0) begin
                    write_cfg(hart_pkg::CFG_ADDR_QUANTUM, 32'(q));  // Live mid-turn.
                end
                fetched[ring_pos]++;
                next_cycle();
            end
            ring_pos = ring_pos + 1'b1;             // Wraps after hart 3.
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        int errs_now;
        errs_now = check_errors + model_errors;
        if (errs_now == errs_before) begin
            tests_passed++;
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail, %0d errors", name, errs_now - errs_before);
        end
    endtask

    task automatic check_reset_state();
        apply_reset();
        wait_for_valid(4);
        check_eq("halt_proc", 32'd0, 32'(halt_proc));
        for (int h = 0; h < hart_pkg::NUM_HARTS; h++) begin
            check_eq("fetch.hart", 32'(h), 32'(fetch.hart));
            check_eq("fetch.pc", reset_pc(hart_pkg::hart_id_t'(h)), fetch.pc);
            events.pc_en      = 1'b1;               // First fetch, then move on.
            events.cache_miss = 1'b1;
            next_cycle();
        end
        check_eq("fetch.pc", reset_pc(2'd0) + 32'd4, fetch.pc);
        events.pc_en = 1'b0;
    endtask

    task automatic rotate_on_quantum();
        apply_reset();
        fetched      = '{default: 0};
        ring_pos     = '0;
        events.pc_en = 1'b1;
        wait_for_valid(4);
        rotate_turns(5, int'(hart_pkg::RESET_QUANTUM), 1'b0);
        rotate_turns(5, 3, 1'b1);                   // Shorter turns after the write.
        events.pc_en = 1'b0;
    endtask

    task automatic switch_on_miss();
        logic b;
        apply_reset();
        events.pc_en = 1'b1;
        wait_for_valid(4);
        repeat (5) next_cycle();
        events.cache_miss = 1'b1;
        next_cycle();
        check_eq("fetch.hart", 32'd1, 32'(fetch.hart));
        check_eq("fetch.pc", reset_pc(2'd1), fetch.pc);
        repeat (int'(hart_pkg::RESET_QUANTUM) - 1) begin
            check_eq("fetch.hart", 32'd1, 32'(fetch.hart));  // Full fresh turn.
            next_cycle();
        end
        check_eq("fetch.hart", 32'd1, 32'(fetch.hart));
        next_cycle();
        check_eq("fetch.hart", 32'd2, 32'(fetch.hart));
        repeat (130) begin
            take_bits(2, b);
            events.pc_en = !b;                      // Low one cycle in four.
            take_bits(3, b);
            events.flush = b;
            take_bits(3, b);
            events.cache_miss = b;
            next_cycle();
        end
        events = '0;
    endtask

    task automatic mask_harts();
        hart_pkg::hart_id_t keep;
        apply_reset();
        events.pc_en = 1'b1;
        wait_for_valid(4);
        write_cfg(hart_pkg::CFG_ADDR_ENABLE, 32'h5);  // Harts 0 and 2.
        next_cycle();
        repeat (40) begin
            check_eq("fetch.hart[0]", 32'd0, 32'(fetch.hart[0]));
            next_cycle();
        end
        events.pc_en = 1'b0;
        keep         = fetch.hart;
        write_cfg(hart_pkg::CFG_ADDR_ENABLE, 32'd1 << keep);
        next_cycle();
        events.pc_en = 1'b1;
        repeat (4) begin
            events.cache_miss = 1'b1;
            next_cycle();
            check_eq("fetch.hart", 32'(keep), 32'(fetch.hart));
            check_eq("fetch.valid", 32'd1, 32'(fetch.valid));
        end
        write_cfg(hart_pkg::CFG_ADDR_ENABLE, 32'd0);
        next_cycle();
        repeat (3) begin
            check_eq("fetch.valid", 32'd0, 32'(fetch.valid));
            check_eq("halt_proc", 32'd0, 32'(halt_proc));
            next_cycle();
        end
        events.pc_en = 1'b0;
    endtask

    task automatic redirect_pcs();
        apply_reset();
        events.pc_en = 1'b1;
        wait_for_valid(4);
        redirect = '{valid: 1'b1, hart: 2'd0, target: 32'h4000_0000};  // Beats the step.
        next_cycle();
        check_eq("fetch.pc", 32'h4000_0000, fetch.pc);
        redirect = '{valid: 1'b1, hart: 2'd2, target: 32'h8000_0040};  // Idle hart.
        next_cycle();
        check_eq("fetch.pc", 32'h4000_0004, fetch.pc);
        events.pc_en = 1'b0;
        repeat (2) begin
            events.cache_miss = 1'b1;
            next_cycle();
        end
        check_eq("fetch.hart", 32'd2, 32'(fetch.hart));
        check_eq("fetch.pc", 32'h8000_0040, fetch.pc);
        events.pc_en = 1'b1;
        next_cycle();
        check_eq("fetch.pc", 32'h8000_0044, fetch.pc);
        events.pc_en = 1'b0;
    endtask

    task automatic terminate_harts();
        apply_reset();
        events.pc_en = 1'b1;
        wait_for_valid(4);
        end_thread(2'd2);                           // Any termination switches.
        check_eq("fetch.hart", 32'd1, 32'(fetch.hart));
        repeat (3) next_cycle();
        end_thread(2'd1);
        check_eq("fetch.hart", 32'd3, 32'(fetch.hart));
        end_thread(2'd3);
        check_eq("fetch.hart", 32'd0, 32'(fetch.hart));
        repeat (25) begin
            check_eq("fetch.hart", 32'd0, 32'(fetch.hart));  // Sole survivor holds.
            next_cycle();
        end
        end_thread(2'd0);
        repeat (5) begin
            check_eq("halt_proc", 32'd1, 32'(halt_proc));
            check_eq("fetch.valid", 32'd0, 32'(fetch.valid));
            events.cache_miss = 1'b1;
            next_cycle();
        end
        apply_reset();
        wait_for_valid(4);
        check_eq("halt_proc", 32'd0, 32'(halt_proc));
        events.pc_en = 1'b0;
    endtask

    initial begin
        CLK      = 1'b0;
        nRST     = 1'b0;
        cfg      = '0;
        events   = '0;
        redirect = '0;
        err_mark = check_errors + model_errors;
        check_reset_state();
        end_test("reset state", err_mark);
        err_mark = check_errors + model_errors;
        rotate_on_quantum();
        end_test("quantum rotation", err_mark);
        err_mark = check_errors + model_errors;
        switch_on_miss();
        end_test("cache miss", err_mark);
        err_mark = check_errors + model_errors;
        mask_harts();
        end_test("enable mask", err_mark);
        err_mark = check_errors + model_errors;
        redirect_pcs();
        end_test("redirect", err_mark);
        err_mark = check_errors + model_errors;
        terminate_harts();
        end_test("termination", err_mark);
        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 check_errors + model_errors);
        if (tests_failed == 0 && check_errors + model_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/mt_fetch_top.sv */
/* Thread-selection front end of the fetch stage. Connects the scheduling registers,
   hart selector and PC file, and forms the fetch request from their registered state. */
`timescale 1ns/1ps
`default_nettype none

module mt_fetch_top (
    input  logic                    CLK,
    input  logic                    nRST,
    input  hart_pkg::cfg_write_t    cfg,
    input  hart_pkg::pipe_events_t  events,
    input  hart_pkg::redirect_t     redirect,
    output hart_pkg::fetch_req_t    fetch,
    output logic                    halt_proc
);

    hart_pkg::sched_cfg_t sched;        // Quantum and enable mask.
    hart_pkg::hart_id_t   hart_id;      // Selected hart.
    hart_pkg::word_t      pc;           // Its PC.
    logic                 fetch_step;   // A fetch completes this cycle.
    logic                 eligible;     // Selected hart may fetch.

    hart_sched_regs sched_regs_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .cfg   (cfg),
        .sched (sched)
    );

    hart_selector selector_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .events     (events),
        .sched      (sched),
        .hart_id    (hart_id),
        .fetch_step (fetch_step),
        .eligible   (eligible),
        .halt_proc  (halt_proc)
    );

    hart_pc_file pc_file_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .hart_id    (hart_id),
        .fetch_step (fetch_step),
        .redirect   (redirect),
        .pc         (pc)
    );

    // Request follows the registered state with no extra delay.
    always_comb begin
        fetch       = '0;
        fetch.valid = eligible && !halt_proc;
        fetch.hart  = hart_id;
        fetch.pc    = pc;
    end

endmodule

`default_nettype wire

/* hw/hart_pc_file.sv */
/* One program counter per hart. The selected hart steps by 4 on each fetch,
   and execute may redirect any hart; the selected hart's PC is the fetch address. */
`timescale 1ns/1ps
`default_nettype none

module hart_pc_file (
    input  logic                 CLK,
    input  logic                 nRST,
    input  hart_pkg::hart_id_t   hart_id,
    input  logic                 fetch_step,
    input  hart_pkg::redirect_t  redirect,
    output hart_pkg::word_t      pc
);

    hart_pkg::word_t pc_q    [hart_pkg::NUM_HARTS];  // Per-hart PCs.
    hart_pkg::word_t pc_next [hart_pkg::NUM_HARTS];
    hart_pkg::word_t pc_rst  [hart_pkg::NUM_HARTS];  // Per-hart boot PC.

    // Boot address of each hart.
    always_comb begin
        for (int h = 0; h < hart_pkg::NUM_HARTS; h++) begin
            pc_rst[h] = hart_pkg::RESET_PC_BASE +
                        (hart_pkg::word_t'(h) * hart_pkg::HART_PC_STRIDE);
        end
    end

    // Next PC per hart; the redirect overrides the step.
    always_comb begin
        for (int h = 0; h < hart_pkg::NUM_HARTS; h++) begin
            pc_next[h] = pc_q[h];
            if (fetch_step && (hart_id == hart_pkg::hart_id_t'(h))) begin
                pc_next[h] = pc_q[h] + 32'd4;       // Sequential fetch.
            end
            if (redirect.valid && (redirect.hart == hart_pkg::hart_id_t'(h))) begin
                pc_next[h] = redirect.target;       // Branch or jump target.
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int h = 0; h < hart_pkg::NUM_HARTS; h++) begin
                pc_q[h] <= pc_rst[h];
            end
        end else begin
            for (int h = 0; h < hart_pkg::NUM_HARTS; h++) begin
                pc_q[h] <= pc_next[h];
            end
        end
    end

    // Fetch address of the selected hart.
    assign pc = pc_q[hart_id];

endmodule

`default_nettype wire

/* hart_select/hart_selector.sv */
/* Picks the hart that fetches next. It tracks live harts and the quantum count and
   rotates round robin on a miss, a termination or an expired quantum. */
`timescale 1ns/1ps
`default_nettype none

module hart_selector (
    input  logic                    CLK,
    input  logic                    nRST,
    input  hart_pkg::pipe_events_t  events,
    input  hart_pkg::sched_cfg_t    sched,
    output hart_pkg::hart_id_t      hart_id,
    output logic                    fetch_step,
    output logic                    eligible,
    output logic                    halt_proc
);

    hart_pkg::hart_mask_t           live;           // Harts not yet terminated.
    hart_pkg::hart_mask_t           next_live;
    hart_pkg::hart_mask_t           elig_mask;      // Live and enabled, after this cycle's term.
    logic [hart_pkg::QUANTUM_W-1:0] count;          // Fetches in current turn.
    logic [hart_pkg::QUANTUM_W-1:0] next_count;
    hart_pkg::hart_id_t             next_hart_id;
    logic                           armed;          // Set once reset is released.
    logic                           quantum_done;   // This fetch ends the turn.
    logic                           switch_hart;    // Any switch cause.

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            live    <= '1;                          // Every hart starts live.
            count   <= '0;
            hart_id <= '0;                          // Hart 0 fetches first.
            armed   <= 1'b0;
        end else begin
            live    <= next_live;
            count   <= next_count;
            hart_id <= next_hart_id;
            armed   <= 1'b1;
        end
    end

    // Fetching starts the cycle after reset is released.
    assign eligible   = armed && live[hart_id] && sched.enable[hart_id];
    assign fetch_step = events.pc_en && !events.flush && eligible;
    assign halt_proc  = ~|live;                     // Nobody left to run.

    // Drop a terminating hart from the live mask.
    always_comb begin
        next_live = live;
        if (events.thread_terminated) begin
            next_live[events.term_hart] = 1'b0;
        end
    end

    assign elig_mask = next_live & sched.enable;

    // Compare one bit wider so a lowered quantum still ends the turn.
    assign quantum_done = fetch_step &&
        (({1'b0, count} + 1'b1) >= {1'b0, sched.quantum});

    assign switch_hart = events.cache_miss || events.thread_terminated || quantum_done;

    // Quantum count.
    always_comb begin
        if (switch_hart) begin
            next_count = '0;                        // Also covers a lone miss.
        end else if (fetch_step) begin
            next_count = count + 1'b1;
        end else begin
            next_count = count;                     // Stalled or flushed.
        end
    end

    // Round-robin search upward from the current hart.
    always_comb begin
        hart_pkg::hart_id_t cand;
        logic               found;
        next_hart_id = hart_id;                     // Hold if nothing else qualifies.
        found        = 1'b0;
        cand         = hart_id;
        if (switch_hart) begin
            for (int i = 1; i < hart_pkg::NUM_HARTS; i++) begin
                cand = hart_pkg::hart_id_t'((int'(hart_id) + i) % hart_pkg::NUM_HARTS);
                if (!found && elig_mask[cand]) begin
                    next_hart_id = cand;            // First eligible after current.
                    found        = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hart_select/hart_sched_regs.sv */
/* Write-only scheduling registers holding the fetch quantum and the hart enable mask.
   Software writes them with single-cycle strobes; the selector sees them next cycle. */
`timescale 1ns/1ps
`default_nettype none

module hart_sched_regs (
    input  logic                  CLK,
    input  logic                  nRST,
    input  hart_pkg::cfg_write_t  cfg,
    output hart_pkg::sched_cfg_t  sched
);

    logic [hart_pkg::QUANTUM_W-1:0] quantum;        // Current quantum length.
    logic [hart_pkg::QUANTUM_W-1:0] wr_quantum;     // Quantum as it would be written.
    hart_pkg::hart_mask_t           enable;         // Current enable mask.
    logic                           wr_quantum_en;  // Write hits quantum.
    logic                           wr_enable_en;   // Write hits enable mask.

    // Address decode.
    always_comb begin
        wr_quantum_en = 1'b0;
        wr_enable_en  = 1'b0;
        if (cfg.wr) begin
            case (cfg.addr)
                hart_pkg::CFG_ADDR_QUANTUM: wr_quantum_en = 1'b1;
                hart_pkg::CFG_ADDR_ENABLE:  wr_enable_en  = 1'b1;
                default: ;
            endcase
        end
    end

    // A zero quantum would starve every hart, so it becomes one.
    always_comb begin
        wr_quantum = cfg.data[hart_pkg::QUANTUM_W-1:0];
        if (wr_quantum == '0) begin
            wr_quantum = hart_pkg::QUANTUM_W'(1);   // Minimum of one fetch.
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            quantum <= hart_pkg::RESET_QUANTUM;     // Default turn length.
            enable  <= '1;                          // All harts enabled.
        end else begin
            if (wr_quantum_en) begin
                quantum <= wr_quantum;
            end
            if (wr_enable_en) begin
                enable <= cfg.data[hart_pkg::NUM_HARTS-1:0];  // Low bits only.
            end
        end
    end

    // Pack for the selector.
    always_comb begin
        sched         = '0;
        sched.quantum = quantum;
        sched.enable  = enable;
    end

endmodule

`default_nettype wire

/* common/hart_pkg.sv */
/* Shared widths, reset values and bus structs for the multithreaded fetch front end.
   Modules refer to these by scoped name. */
`default_nettype none

package hart_pkg;

    // Thread configuration.
    localparam int NUM_HARTS = 4;                 // Hardware threads.
    localparam int HART_ID_W = 2;                 // Bits to index a hart.
    localparam int QUANTUM_W = 4;                 // Quantum counter width.

    typedef logic [31:0]          word_t;         // Data and address word.
    typedef logic [HART_ID_W-1:0] hart_id_t;      // Hart index.
    typedef logic [NUM_HARTS-1:0] hart_mask_t;    // One bit per hart.
    typedef logic [0:0]           cfg_addr_t;     // Scheduling register address.

    // Eleven fetches per turn out of reset.
    localparam logic [QUANTUM_W-1:0] RESET_QUANTUM = 4'd11;

    // Hart n boots at base plus n strides.
    localparam word_t RESET_PC_BASE  = 32'h0000_0200;
    localparam word_t HART_PC_STRIDE = 32'h0000_1000;

    localparam cfg_addr_t CFG_ADDR_QUANTUM = 1'b0;  // Quantum length.
    localparam cfg_addr_t CFG_ADDR_ENABLE  = 1'b1;  // Hart enable mask.

    // Current scheduling setup, fed to the selector.
    typedef struct packed {
        logic [QUANTUM_W-1:0] quantum;            // Fetches per turn, never zero.
        hart_mask_t           enable;             // Software enable per hart.
    } sched_cfg_t;

    // Software write port, one strobe per write.
    typedef struct packed {
        logic      wr;                            // Write strobe.
        cfg_addr_t addr;                          // Target register.
        word_t     data;                          // Write data.
    } cfg_write_t;

    // Pipeline events seen by the selector.
    typedef struct packed {
        logic     pc_en;                          // Fetch allowed, a level.
        logic     flush;                          // Fetch squashed this cycle.
        logic     cache_miss;                     // Miss pulse from I-cache.
        logic     thread_terminated;              // Termination pulse.
        hart_id_t term_hart;                      // Hart that terminated.
    } pipe_events_t;

    // Execute redirect of one hart's PC.
    typedef struct packed {
        logic     valid;                          // Redirect pulse.
        hart_id_t hart;                           // Hart to redirect.
        word_t    target;                         // New PC.
    } redirect_t;

    // Request towards instruction memory.
    typedef struct packed {
        logic     valid;                          // Fetch address is usable.
        hart_id_t hart;                           // Fetching hart.
        word_t    pc;                             // Fetch address.
    } fetch_req_t;

endpackage

`default_nettype wire
